// ==== design/memPkg.sv ====
package memPkg;

    localparam int addrWidth = 17;  // Byte address, sets the RAM size
    localparam int dataWidth = 32;
    localparam int lenWidth  = 2;

    localparam int ramBytes = 1 << addrWidth;

    // Length codes hold the byte count minus one
    localparam logic [lenWidth-1:0] lenByte = 2'd0;
    localparam logic [lenWidth-1:0] lenHalf = 2'd1;
    localparam logic [lenWidth-1:0] lenWord = 2'd3;

    // Bit positions in the controller wait vector
    localparam int portFetch = 0;
    localparam int portData  = 1;

endpackage

// ==== design/lsuPkg.sv ====
package lsuPkg;

    import memPkg::*;

    localparam int tagWidth   = 4;
    localparam int opDepth    = 8;
    localparam int fetchDepth = 4;

    // One queued load or store with its reservation tag
    typedef struct packed {
        logic                 store;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;   // Store data, ignored for loads
        logic [lenWidth-1:0]  len;
        logic [tagWidth-1:0]  tag;
    } lsOp_t;

    // Instruction fetch is always a full word
    typedef struct packed {
        logic [addrWidth-1:0] addr;
    } fetchReq_t;

endpackage

// ==== design/syncFifo.sv ====
`timescale 1ns/1ps

module syncFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     push,
    input  payload_t pushData,
    output logic     full,
    input  logic     pop,
    output payload_t popData,
    output logic     empty
);
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);
    localparam logic [ptrWidth:0] fullCount = (ptrWidth + 1)'(depth);

    payload_t            mem [depth];
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth:0]   count;
    logic                doPush;
    logic                doPop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
        return (p == lastPtr) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == fullCount);
    assign empty   = (count == '0);
    assign doPop   = rdy && pop && !empty;
    assign doPush  = rdy && push && (!full || doPop);  // Full queue takes a push on a pop
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/loadStoreBuffer.sv ====
`timescale 1ns/1ps

module loadStoreBuffer import memPkg::*, lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    // Operation entry in program order
    input  logic                 opValid,
    input  logic                 opStore,
    input  logic [addrWidth-1:0] opAddr,
    input  logic [dataWidth-1:0] opData,
    input  logic [lenWidth-1:0]  opLen,
    input  logic [tagWidth-1:0]  opTag,
    output logic                 opReady,

    // Access slot side
    input  logic                 slotFree,
    output logic                 issueEn,
    output lsOp_t                issueOp
);
    lsOp_t newOp;
    logic  full;
    logic  empty;
    logic  accept;

    assign newOp = '{
        store: opStore,
        addr:  opAddr,
        data:  opData,
        len:   opLen,
        tag:   opTag
    };

    assign opReady = rdy && !full;
    assign accept  = opValid && opReady;

    // Head leaves only when the slot can take it, so loads and stores stay in order
    assign issueEn = rdy && slotFree && !empty;

    syncFifo #(
        .payload_t (lsOp_t),
        .depth     (opDepth)
    ) opQueue (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .push     (accept),
        .pushData (newOp),
        .full     (full),
        .pop      (issueEn),
        .popData  (issueOp),
        .empty    (empty)
    );

endmodule

// ==== design/dataAccessSlot.sv ====
`timescale 1ns/1ps

module dataAccessSlot import memPkg::*, lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    // From the load/store buffer
    input  logic                 issueEn,
    input  lsOp_t                issueOp,
    output logic                 slotFree,

    // Memory controller data port
    input  logic                 memWait,
    input  logic                 memDone,
    input  logic [dataWidth-1:0] memRdata,
    output logic                 memEn,
    output logic                 memStore,
    output logic [addrWidth-1:0] memAddr,
    output logic [dataWidth-1:0] memData,
    output logic [lenWidth-1:0]  memLen,

    // Tagged result
    output logic                 resDone,
    output logic [dataWidth-1:0] resData,
    output logic [tagWidth-1:0]  resTag
);
    lsOp_t held;
    logic  occupied;
    logic  resDoneQ;

    // Free during reset too, the buffer is empty then anyway
    assign slotFree = rst || (rdy && !occupied);

    // Request stays up until the controller has latched it
    assign memEn    = rdy && occupied && !memWait;
    assign memStore = held.store;
    assign memAddr  = held.addr;
    assign memData  = held.data;
    assign memLen   = held.len;

    assign resDone = rdy && resDoneQ;  // Pulse waits out a stall

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            held <= issueOp;
        end
        if (rdy && memDone) begin
            resData <= memRdata;
            resTag  <= held.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            resDoneQ <= 1'b0;
        end else if (rdy) begin
            resDoneQ <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
            end
            if (issueEn) begin
                occupied <= 1'b1;
            end
        end
    end

endmodule

// ==== design/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl import memPkg::*, lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    // Data port from the access slot
    input  logic                 memEn,
    input  logic                 memStore,
    input  logic [addrWidth-1:0] memAddr,
    input  logic [dataWidth-1:0] memData,
    input  logic [lenWidth-1:0]  memLen,

    // Fetch queue head
    input  logic                 fetchEmpty,
    input  fetchReq_t            fetchAddr,
    output logic                 fetchPop,

    output logic [1:0]           memWait,
    output logic                 memDone,
    output logic [dataWidth-1:0] memRdata,
    output logic                 fetchDone,
    output logic [dataWidth-1:0] fetchData,

    // Byte-wide RAM
    output logic [addrWidth-1:0] ramAddr,
    output logic                 ramWe,
    output logic [7:0]           ramWdata,
    input  logic [7:0]           ramRdata
);
    typedef enum logic {
        stIdle,
        stBusy
    } state_t;

    state_t               state;
    logic                 servingData;
    logic                 storeQ;
    logic [addrWidth-1:0] baseQ;
    logic [dataWidth-1:0] wdataQ;
    logic [lenWidth-1:0]  lastQ;
    logic [lenWidth:0]    idx;        // Next byte to access, one ahead of the capture
    logic [dataWidth-1:0] rbuf;
    logic [addrWidth-1:0] holdAddr;
    logic                 memDoneQ;
    logic                 fetchDoneQ;

    logic                 startData;
    logic                 startFetch;
    logic [lenWidth-1:0]  capIdx;
    logic                 lastByte;
    logic [dataWidth-1:0] wshift;
    logic [dataWidth-1:0] rmerged;
    logic [addrWidth-1:0] accAddr;

    // Data wins, arbitration only from idle
    assign startData  = rdy && (state == stIdle) && memEn;
    assign startFetch = rdy && (state == stIdle) && !memEn && !fetchEmpty;
    assign fetchPop   = startFetch;

    assign capIdx   = lenWidth'(idx - 1'b1);
    assign lastByte = (capIdx == lastQ);
    assign wshift   = wdataQ >> {idx, 3'b000};
    assign rmerged  = rbuf | (dataWidth'(ramRdata) << {capIdx, 3'b000});

    // Byte 0 goes out in the start cycle, the rest one per busy cycle
    always_comb begin
        if (state == stIdle) begin
            accAddr  = startData ? memAddr : fetchAddr.addr;
            ramWe    = startData && memStore;
            ramWdata = memData[7:0];
        end else begin
            accAddr  = baseQ + addrWidth'(idx);
            ramWe    = rdy && storeQ && (idx <= {1'b0, lastQ});
            ramWdata = wshift[7:0];
        end
    end

    // During a stall the RAM re-reads the byte still to be captured
    assign ramAddr = rdy ? accAddr : holdAddr;

    assign memWait[portData]  = (state == stBusy && servingData) || memDoneQ;
    assign memWait[portFetch] = (state == stBusy && !servingData) || fetchDoneQ;

    assign memDone   = rdy && memDoneQ;
    assign fetchDone = rdy && fetchDoneQ;
    assign memRdata  = rbuf;
    assign fetchData = rbuf;

    always_ff @(posedge clk) begin
        if (rdy) begin
            holdAddr <= accAddr;
            if (startData) begin
                storeQ <= memStore;
                baseQ  <= memAddr;
                wdataQ <= memData;
                lastQ  <= memLen;
            end else if (startFetch) begin
                storeQ <= 1'b0;
                baseQ  <= fetchAddr.addr;
                lastQ  <= lenWord;
            end
            if (startData || startFetch) begin
                rbuf <= '0;  // Zero fill above the access length
            end else if (state == stBusy && !storeQ) begin
                rbuf <= rmerged;  // Little-endian assembly
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stIdle;
            servingData <= 1'b0;
            idx         <= '0;
            memDoneQ    <= 1'b0;
            fetchDoneQ  <= 1'b0;
        end else if (rdy) begin
            memDoneQ   <= 1'b0;
            fetchDoneQ <= 1'b0;
            if (state == stIdle) begin
                if (startData || startFetch) begin
                    state       <= stBusy;
                    servingData <= startData;
                    idx         <= {{lenWidth{1'b0}}, 1'b1};
                end
            end else if (lastByte) begin
                state      <= stIdle;
                memDoneQ   <= servingData;
                fetchDoneQ <= !servingData;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// ==== design/ramModel.sv ====
`timescale 1ns/1ps

module ramModel import memPkg::*; (
    input  logic                 clk,
    input  logic [addrWidth-1:0] addr,
    input  logic                 we,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);
    logic [7:0] mem [ramBytes];

    // Read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== design/lsuTop.sv ====
`timescale 1ns/1ps

module lsuTop import memPkg::*, lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    input  logic                 opValid,
    input  logic                 opStore,
    input  logic [addrWidth-1:0] opAddr,
    input  logic [dataWidth-1:0] opData,
    input  logic [lenWidth-1:0]  opLen,
    input  logic [tagWidth-1:0]  opTag,
    output logic                 opReady,

    output logic                 resDone,
    output logic [dataWidth-1:0] resData,
    output logic [tagWidth-1:0]  resTag,

    input  logic                 fetchValid,
    input  logic [addrWidth-1:0] fetchAddr,
    output logic                 fetchReady,
    output logic                 fetchDone,
    output logic [dataWidth-1:0] fetchData
);
    lsOp_t                issueOp;
    logic                 issueEn;
    logic                 slotFree;
    logic                 memEn;
    logic                 memStore;
    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memData;
    logic [lenWidth-1:0]  memLen;
    logic [1:0]           memWait;
    logic                 memDone;
    logic [dataWidth-1:0] memRdata;
    fetchReq_t            fetchIn;
    fetchReq_t            fetchHead;
    logic                 fetchFull;
    logic                 fetchEmpty;
    logic                 fetchPop;
    logic                 fetchPush;
    logic [addrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    assign fetchReady = rdy && !fetchFull;
    assign fetchPush  = fetchValid && fetchReady;
    assign fetchIn    = '{addr: fetchAddr};

    loadStoreBuffer lsBuf (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .opValid  (opValid),
        .opStore  (opStore),
        .opAddr   (opAddr),
        .opData   (opData),
        .opLen    (opLen),
        .opTag    (opTag),
        .opReady  (opReady),
        .slotFree (slotFree),
        .issueEn  (issueEn),
        .issueOp  (issueOp)
    );

    dataAccessSlot slot (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .issueEn  (issueEn),
        .issueOp  (issueOp),
        .slotFree (slotFree),
        .memWait  (memWait[portData]),
        .memDone  (memDone),
        .memRdata (memRdata),
        .memEn    (memEn),
        .memStore (memStore),
        .memAddr  (memAddr),
        .memData  (memData),
        .memLen   (memLen),
        .resDone  (resDone),
        .resData  (resData),
        .resTag   (resTag)
    );

    syncFifo #(
        .payload_t (fetchReq_t),
        .depth     (fetchDepth)
    ) fetchQueue (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .push     (fetchPush),
        .pushData (fetchIn),
        .full     (fetchFull),
        .pop      (fetchPop),
        .popData  (fetchHead),
        .empty    (fetchEmpty)
    );

    memCtrl ctrl (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .memEn      (memEn),
        .memStore   (memStore),
        .memAddr    (memAddr),
        .memData    (memData),
        .memLen     (memLen),
        .fetchEmpty (fetchEmpty),
        .fetchAddr  (fetchHead),
        .fetchPop   (fetchPop),
        .memWait    (memWait),
        .memDone    (memDone),
        .memRdata   (memRdata),
        .fetchDone  (fetchDone),
        .fetchData  (fetchData),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata),
        .ramRdata   (ramRdata)
    );

    ramModel ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== sim/lsuTb.sv ====
`timescale 1ns/1ps

module lsuTb import memPkg::*, lsuPkg::*; ();

    localparam int timeoutCycles = 300;
    localparam int quietCycles   = 40;
    localparam int preloadWords  = 16;
    localparam int fetchCount    = 12;
    localparam logic [addrWidth-1:0] fetchBase = 17'h10000;

    typedef struct packed {
        lsOp_t                op;
        logic [dataWidth-1:0] expData;  // Hand-derived load result, zero for stores
    } tableRow_t;

    typedef struct packed {
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } result_t;

    logic clk, rst, rdy, stallOn;
    logic opValid, opStore, opReady;
    logic [addrWidth-1:0] opAddr;
    logic [dataWidth-1:0] opData;
    logic [lenWidth-1:0]  opLen;
    logic [tagWidth-1:0]  opTag;
    logic resDone, fetchValid, fetchReady, fetchDone;
    logic [dataWidth-1:0] resData, fetchData;
    logic [tagWidth-1:0]  resTag;
    logic [addrWidth-1:0] fetchAddr;

    logic [7:0]           refMem [ramBytes];
    tableRow_t            opTable[$];
    result_t              expRes[$];
    logic [dataWidth-1:0] expFetch[$];

    lsuTop i_dut (.*);

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (stallOn) begin
            rdy <= (($urandom % 8) != 0);  // About one stall cycle in eight
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic tableRow_t makeRow(input logic st, input logic [addrWidth-1:0] a,
            input logic [dataWidth-1:0] d, input logic [lenWidth-1:0] len,
            input logic [tagWidth-1:0] tag, input logic [dataWidth-1:0] expData);
        tableRow_t row;
        row.op.store = st;
        row.op.addr  = a;
        row.op.data  = d;
        row.op.len   = len;
        row.op.tag   = tag;
        row.expData  = expData;
        return row;
    endfunction

    // Little-endian, zero-extended
    function automatic logic [dataWidth-1:0] loadRef(input logic [addrWidth-1:0] a,
                                                     input logic [lenWidth-1:0] len);
        logic [dataWidth-1:0] value;
        value = '0;
        for (int b = 0; b <= int'(len); b++) begin
            value[8*b +: 8] = refMem[a + addrWidth'(b)];
        end
        return value;
    endfunction

    task automatic storeRef(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d,
                            input logic [lenWidth-1:0] len);
        for (int b = 0; b <= int'(len); b++) begin
            refMem[a + addrWidth'(b)] = d[8*b +: 8];
        end
    endtask

    task automatic buildTable();
        opTable.push_back(makeRow(1'b1, 17'h00100, 32'hDEADBEEF, lenWord, 4'd1,  32'h0));
        opTable.push_back(makeRow(1'b0, 17'h00100, 32'h0,        lenWord, 4'd2,  32'hDEADBEEF));
        opTable.push_back(makeRow(1'b1, 17'h00104, 32'h11223344, lenWord, 4'd3,  32'h0));
        opTable.push_back(makeRow(1'b1, 17'h00101, 32'h000000A5, lenByte, 4'd4,  32'h0));
        opTable.push_back(makeRow(1'b1, 17'h00103, 32'h0000C3D2, lenHalf, 4'd5,  32'h0));
        opTable.push_back(makeRow(1'b0, 17'h00100, 32'h0,        lenWord, 4'd6,  32'hD2ADA5EF));
        opTable.push_back(makeRow(1'b0, 17'h00102, 32'h0,        lenHalf, 4'd7,  32'h0000D2AD));
        opTable.push_back(makeRow(1'b0, 17'h00103, 32'h0,        lenByte, 4'd8,  32'h000000D2));
        opTable.push_back(makeRow(1'b0, 17'h00101, 32'h0,        lenWord, 4'd9,  32'hC3D2ADA5));
        opTable.push_back(makeRow(1'b1, 17'h00105, 32'h0000BEEF, lenHalf, 4'd10, 32'h0));
        opTable.push_back(makeRow(1'b0, 17'h00104, 32'h0,        lenWord, 4'd11, 32'h11BEEFC3));
        opTable.push_back(makeRow(1'b0, 17'h00105, 32'h0,        lenHalf, 4'd12, 32'h0000BEEF));
        opTable.push_back(makeRow(1'b1, 17'h00107, 32'h12345678, lenWord, 4'd13, 32'h0));
        opTable.push_back(makeRow(1'b0, 17'h00106, 32'h0,        lenWord, 4'd14, 32'h345678BE));
        opTable.push_back(makeRow(1'b0, 17'h00109, 32'h0,        lenHalf, 4'd15, 32'h00001234));
        opTable.push_back(makeRow(1'b0, 17'h0010A, 32'h0,        lenByte, 4'd0,  32'h00000012));
    endtask

    task automatic applyOp(input tableRow_t row);
        int      waitCycles;
        result_t exp;
        waitCycles = 0;
        @(negedge clk);
        opValid <= 1'b1;
        opStore <= row.op.store;
        opAddr  <= row.op.addr;
        opData  <= row.op.data;
        opLen   <= row.op.len;
        opTag   <= row.op.tag;
        #1;
        while (!opReady) begin
            waitCycles++;
            assert (waitCycles < timeoutCycles)
                else abortRun("The operation queue never accepted an operation");
            @(negedge clk);
            #1;
        end
        // Taken at the coming rising edge
        exp.tag = row.op.tag;
        if (row.op.store) begin
            storeRef(row.op.addr, row.op.data, row.op.len);
            exp.data = '0;
        end else begin
            exp.data = loadRef(row.op.addr, row.op.len);
        end
        assert (exp.data == row.expData)
            else abortRun($sformatf("Reference memory and table disagree for tag %0d", exp.tag));
        expRes.push_back(exp);
    endtask

    task automatic preloadFetchRegion();
        logic [addrWidth-1:0] a;
        for (int k = 0; k < preloadWords; k++) begin
            a = fetchBase + addrWidth'(4 * k);
            applyOp(makeRow(1'b1, a, {a[14:0], a} ^ 32'h5A5AC3C3, lenWord, tagWidth'(k), '0));
        end
        @(negedge clk);
        opValid <= 1'b0;
    endtask

    task automatic applyTable();
        foreach (opTable[i]) begin
            applyOp(opTable[i]);
        end
        @(negedge clk);
        opValid <= 1'b0;
    endtask

    task automatic requestFetches(input int count);
        int                   waitCycles;
        logic [addrWidth-1:0] a;
        for (int n = 0; n < count; n++) begin
            a = fetchBase + addrWidth'($urandom % 61);  // Whole word stays in the preloaded region
            waitCycles = 0;
            @(negedge clk);
            fetchValid <= 1'b1;
            fetchAddr  <= a;
            #1;
            while (!fetchReady) begin
                waitCycles++;
                assert (waitCycles < timeoutCycles)
                    else abortRun("The fetch queue never accepted a fetch");
                @(negedge clk);
                #1;
            end
            expFetch.push_back(loadRef(a, lenWord));
        end
        @(negedge clk);
        fetchValid <= 1'b0;
    endtask

    task automatic checkResults(input int count);
        int      got;
        int      waitCycles;
        result_t exp;
        got = 0;
        waitCycles = 0;
        while (got < count) begin
            @(negedge clk);
            #1;
            assert (rdy || !resDone)
                else abortRun($sformatf("** Error at %0t: resDone = %b while stalled, expected 0",
                                        $time, resDone));
            if (resDone) begin
                assert (expRes.size() > 0) else abortRun("A result came with no operation pending");
                exp = expRes.pop_front();
                assert (resTag == exp.tag)
                    else abortRun($sformatf("** Error at %0t: resTag = %0d, expected %0d",
                                            $time, resTag, exp.tag));
                assert (resData == exp.data)
                    else abortRun($sformatf("** Error at %0t: resData = %h, expected %h",
                                            $time, resData, exp.data));
                got++;
                waitCycles = 0;
            end else begin
                waitCycles++;
                assert (waitCycles < timeoutCycles) else abortRun("Timed out waiting for a result");
            end
        end
    endtask

    task automatic checkFetches(input int count);
        int                   got;
        int                   waitCycles;
        logic [dataWidth-1:0] exp;
        got = 0;
        waitCycles = 0;
        while (got < count) begin
            @(negedge clk);
            #1;
            assert (rdy || !fetchDone)
                else abortRun($sformatf("** Error at %0t: fetchDone = %b while stalled, expected 0",
                                        $time, fetchDone));
            if (fetchDone) begin
                assert (expFetch.size() > 0) else abortRun("A fetch result came with none pending");
                exp = expFetch.pop_front();
                assert (fetchData == exp)
                    else abortRun($sformatf("** Error at %0t: fetchData = %h, expected %h",
                                            $time, fetchData, exp));
                got++;
                waitCycles = 0;
            end else begin
                waitCycles++;
                assert (waitCycles < timeoutCycles) else abortRun("Timed out waiting for a fetch");
            end
        end
    endtask

    // Both streams have drained, so any further done pulse is a stray
    task automatic checkQuiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            #1;
            assert (!resDone) else abortRun("A result came with no operation pending");
            assert (!fetchDone) else abortRun("A fetch result came with none pending");
        end
    endtask

    initial begin
        void'($urandom(52));
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        stallOn    = 1'b0;
        opValid    = 1'b0;
        opStore    = 1'b0;
        opAddr     = '0;
        opData     = '0;
        opLen      = '0;
        opTag      = '0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        buildTable();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        #1;
        assert (opReady) else abortRun($sformatf("** Error at %0t: opReady = %b, expected 1",
                                                 $time, opReady));
        assert (fetchReady) else abortRun($sformatf("** Error at %0t: fetchReady = %b, expected 1",
                                                    $time, fetchReady));
        assert (!resDone) else abortRun($sformatf("** Error at %0t: resDone = %b, expected 0",
                                                  $time, resDone));
        assert (!fetchDone) else abortRun($sformatf("** Error at %0t: fetchDone = %b, expected 0",
                                                    $time, fetchDone));
        stallOn = 1'b1;

        // Fetch region gets known contents first
        fork
            preloadFetchRegion();
            checkResults(preloadWords);
        join

        fork
            applyTable();
            checkResults(opTable.size());
            requestFetches(fetchCount);
            checkFetches(fetchCount);
        join

        checkQuiet(quietCycles);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== lsuTop.f ====
design/memPkg.sv
design/lsuPkg.sv
design/syncFifo.sv
design/loadStoreBuffer.sv
design/dataAccessSlot.sv
design/memCtrl.sv
design/ramModel.sv
design/lsuTop.sv
sim/lsuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the lsuTop testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert -f lsuTop.f --top-module lsuTb \
    --Mdir "$buildDir" -o lsuSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/lsuSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Testbench passed" "$logFile"; then
    exit 0
fi
echo "Pass line not found in $logFile"
exit 1
